//--- include/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// cache geometry
`define CACHE_LINE_ADDR_LEN    3     // word index bits, 8 words per line
`define CACHE_SET_ADDR_LEN     3     // 8 sets
`define CACHE_TAG_ADDR_LEN     6
`define CACHE_WAY_CNT          4     // ways per set
`define CACHE_WAY_IDX_LEN      2

// main memory model
`define CACHE_MEM_LATENCY      4     // strobe rise to gnt

// derived sizes
`define CACHE_LINE_WORDS       (1 << `CACHE_LINE_ADDR_LEN)
`define CACHE_SET_CNT          (1 << `CACHE_SET_ADDR_LEN)
`define CACHE_MEM_ADDR_LEN     (`CACHE_TAG_ADDR_LEN + `CACHE_SET_ADDR_LEN)
`define CACHE_MEM_LINES        (1 << `CACHE_MEM_ADDR_LEN)
`define CACHE_UNUSED_ADDR_LEN  (32 - `CACHE_MEM_ADDR_LEN - `CACHE_LINE_ADDR_LEN - 2)

`endif

//--- logic/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

    typedef logic [`CACHE_TAG_ADDR_LEN-1:0]  tag_t;
    typedef logic [`CACHE_SET_ADDR_LEN-1:0]  set_t;
    typedef logic [`CACHE_LINE_ADDR_LEN-1:0] word_idx_t;
    typedef logic [`CACHE_WAY_IDX_LEN-1:0]   way_t;
    typedef logic [`CACHE_MEM_ADDR_LEN-1:0]  line_addr_t; // {tag, set}

    typedef struct packed {
        logic [`CACHE_UNUSED_ADDR_LEN-1:0] unused; // ignored upper bits
        tag_t                              tag;
        set_t                              set;
        word_idx_t                         word;
        logic [1:0]                        byte_off; // word aligned access
    } addr_fields_t;

    typedef logic [`CACHE_LINE_WORDS-1:0][31:0] line_t; // word 0 in the low bits

    typedef struct packed {
        logic       rd;        // fetch strobe
        logic       wr;        // write-back strobe
        line_addr_t line_addr;
        line_t      wr_line;
    } mem_req_t;

    typedef struct packed {
        logic  gnt;     // one cycle pulse
        line_t rd_line; // valid with gnt
    } mem_rsp_t;

    typedef struct packed {
        logic        en;
        set_t        set;
        way_t        way;
        word_idx_t   word;
        logic [31:0] data;
    } word_wr_t;

    typedef struct packed {
        logic  en;
        set_t  set;
        way_t  way;
        tag_t  tag;
        line_t line;
    } fill_t;

    typedef struct packed {
        logic en;
        set_t set;
        way_t way;
    } lru_touch_t;

endpackage

//--- logic/lru_tracker.sv
`include "cache_settings.svh"

module lru_tracker (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::set_t       set,
    input  cache_pkg::lru_touch_t touch,
    output cache_pkg::way_t       victim_way
);

    localparam int WAYS  = `CACHE_WAY_CNT;
    localparam int SETS  = `CACHE_SET_CNT;
    localparam int WAY_W = `CACHE_WAY_IDX_LEN;
    localparam int CNT_W = $clog2(WAYS + 1);

    typedef logic [WAYS-1:0][WAY_W-1:0] order_t; // slot 0 is least recent

    order_t           order    [SETS];
    logic [CNT_W-1:0] fill_cnt [SETS]; // ways filled so far per set
    order_t           cur;             // order of the touched set
    order_t           moved;           // same order with touched way last
    logic [WAY_W-1:0] pos;             // slot of the touched way
    logic             full;

    // unfilled ways sit in front in index order, so the fill count
    // and the order agree on the next way to fill
    assign full       = (fill_cnt[set] == CNT_W'(WAYS));
    assign victim_way = full ? order[set][0] : fill_cnt[set][WAY_W-1:0];

    always_comb begin
        cur = order[touch.set];
        pos = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (cur[i] == touch.way) begin
                pos = WAY_W'(i);
            end
        end
        for (int i = 0; i < WAYS - 1; i++) begin
            moved[i] = (i < pos) ? cur[i] : cur[i+1]; // close the gap
        end
        moved[WAYS-1] = touch.way; // most recent end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                fill_cnt[s] <= '0;
                for (int i = 0; i < WAYS; i++) begin
                    order[s][i] <= WAY_W'(i);
                end
            end
        end else if (touch.en) begin
            order[touch.set] <= moved;
            // only a miss touches the way at the fill count
            if ((fill_cnt[touch.set] < CNT_W'(WAYS)) &&
                (fill_cnt[touch.set] == CNT_W'(touch.way))) begin
                fill_cnt[touch.set] <= fill_cnt[touch.set] + 1'b1;
            end
        end
    end

endmodule

//--- logic/cache_store.sv
`include "cache_settings.svh"

module cache_store (
    input  logic                 clk,
    input  logic                 rst,
    input  cache_pkg::set_t      set,
    input  cache_pkg::tag_t      tag,
    input  cache_pkg::word_idx_t word_idx,
    input  cache_pkg::way_t      victim_way,
    input  cache_pkg::word_wr_t  word_wr,
    input  cache_pkg::fill_t     fill,
    output logic                 hit,
    output cache_pkg::way_t      hit_way,
    output logic [31:0]          hit_word,
    output cache_pkg::tag_t      victim_tag,
    output cache_pkg::line_t     victim_line,
    output logic                 victim_dirty
);

    localparam int WAYS  = `CACHE_WAY_CNT;
    localparam int SETS  = `CACHE_SET_CNT;
    localparam int WAY_W = `CACHE_WAY_IDX_LEN;

    cache_pkg::line_t lines [SETS][WAYS];
    cache_pkg::tag_t  tags  [SETS][WAYS];
    logic             valid [SETS][WAYS];
    logic             dirty [SETS][WAYS];

    // parallel compare over all ways of the set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (valid[set][i] && (tags[set][i] == tag)) begin
                hit     = 1'b1;
                hit_way = WAY_W'(i); // at most one way matches
            end
        end
    end

    assign hit_word     = lines[set][hit_way][word_idx];
    assign victim_tag   = tags[set][victim_way];
    assign victim_line  = lines[set][victim_way];
    assign victim_dirty = valid[set][victim_way] && dirty[set][victim_way];

    // line data and tags
    always_ff @(posedge clk) begin
        if (fill.en) begin
            lines[fill.set][fill.way] <= fill.line;
            tags[fill.set][fill.way]  <= fill.tag;
        end else if (word_wr.en) begin
            lines[word_wr.set][word_wr.way][word_wr.word] <= word_wr.data;
        end
    end

    // status bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    valid[s][w] <= 1'b0;
                    dirty[s][w] <= 1'b0;
                end
            end
        end else if (fill.en) begin
            valid[fill.set][fill.way] <= 1'b1;
            dirty[fill.set][fill.way] <= 1'b0; // fresh line is clean
        end else if (word_wr.en) begin
            dirty[word_wr.set][word_wr.way] <= 1'b1;
        end
    end

endmodule

//--- logic/line_mem.sv
`include "cache_settings.svh"

module line_mem (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::mem_req_t req,
    output cache_pkg::mem_rsp_t rsp
);

    localparam int LINES = `CACHE_MEM_LINES;
    localparam int WORDS = `CACHE_LINE_WORDS;
    localparam int LAT   = `CACHE_MEM_LATENCY;
    localparam int CNT_W = $clog2(LAT + 1);

    cache_pkg::line_t mem [LINES];
    logic [CNT_W-1:0] cnt;    // cycles the strobe has been held
    logic             active; // either strobe up

    assign active      = req.rd | req.wr;
    assign rsp.gnt     = active && (cnt == CNT_W'(LAT));
    assign rsp.rd_line = mem[req.line_addr];

    // restarts after each gnt so back to back strobes wait again
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (active && !rsp.gnt) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // known pattern per line and word
            for (int a = 0; a < LINES; a++) begin
                for (int w = 0; w < WORDS; w++) begin
                    mem[a][w] <= 32'h1000_0000 + 32'(a * WORDS + w);
                end
            end
        end else if (rsp.gnt && req.wr) begin
            mem[req.line_addr] <= req.wr_line;
        end
    end

endmodule

//--- logic/cache_ctrl.sv
`include "cache_settings.svh"

module cache_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::addr_fields_t addr,
    input  logic                    rd_req,
    input  logic                    wr_req,
    input  logic [31:0]             wr_data,
    input  logic                    hit,
    input  cache_pkg::way_t         hit_way,
    input  logic [31:0]             hit_word,
    input  cache_pkg::tag_t         victim_tag,
    input  cache_pkg::line_t        victim_line,
    input  logic                    victim_dirty,
    output cache_pkg::way_t         victim_way,
    output cache_pkg::word_wr_t     word_wr,
    output cache_pkg::fill_t        fill,
    output cache_pkg::mem_req_t     mem_req,
    input  cache_pkg::mem_rsp_t     mem_rsp,
    output logic                    miss,
    output logic [31:0]             rd_data
);

    localparam int TAG_W = `CACHE_TAG_ADDR_LEN;
    localparam int SET_W = `CACHE_SET_ADDR_LEN;
    localparam int LA_W  = `CACHE_MEM_ADDR_LEN;

    typedef enum logic [1:0] {
        st_idle,
        st_write_back,
        st_fetch,
        st_install
    } state_t;

    state_t                state;
    logic                  req;        // any cpu request
    logic                  idle_hit;   // request served this cycle
    logic                  idle_miss;  // miss seen in idle, latch point
    cache_pkg::line_addr_t miss_line;  // line being fetched
    cache_pkg::line_addr_t wb_addr;    // victim line address
    cache_pkg::line_t      wb_line;    // victim data for write-back
    cache_pkg::line_t      fetched;    // line returned by memory
    cache_pkg::way_t       fill_way;   // way chosen at miss time
    cache_pkg::lru_touch_t touch;

    assign req       = rd_req | wr_req;
    assign idle_hit  = (state == st_idle) && hit;
    assign idle_miss = (state == st_idle) && req && !hit;

    // high while busy or while the lookup misses
    assign miss = req && !idle_hit;

    // every access in idle updates recency, misses touch the victim
    assign touch.en  = (state == st_idle) && req;
    assign touch.set = addr.set;
    assign touch.way = hit ? hit_way : victim_way;

    lru_tracker lru_i (
        .clk        (clk),
        .rst        (rst),
        .set        (addr.set),
        .touch      (touch),
        .victim_way (victim_way)
    );

    // write hit goes straight into the store, read wins if both
    assign word_wr.en   = idle_hit && wr_req && !rd_req;
    assign word_wr.set  = addr.set;
    assign word_wr.way  = hit_way;
    assign word_wr.word = addr.word;
    assign word_wr.data = wr_data;

    // one cycle install after the fetch gnt
    assign fill.en   = (state == st_install);
    assign fill.set  = miss_line[SET_W-1:0];
    assign fill.way  = fill_way;
    assign fill.tag  = miss_line[LA_W-1 -: TAG_W];
    assign fill.line = fetched;

    // strobes decoded from state so only one is ever high
    assign mem_req.rd        = (state == st_fetch);
    assign mem_req.wr        = (state == st_write_back);
    assign mem_req.line_addr = mem_req.wr ? wb_addr : miss_line;
    assign mem_req.wr_line   = wb_line;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            rd_data <= '0;
        end else begin
            if (idle_hit && rd_req) begin
                rd_data <= hit_word; // visible one cycle after miss low
            end
            case (state)
                st_idle: begin
                    if (idle_miss) begin
                        // clean victim skips the write-back
                        state <= victim_dirty ? st_write_back : st_fetch;
                    end
                end
                st_write_back: begin
                    if (mem_rsp.gnt) begin
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (mem_rsp.gnt) begin
                        state <= st_install;
                    end
                end
                st_install: begin
                    state <= st_idle; // held request hits next
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // miss bookkeeping
    always_ff @(posedge clk) begin
        if (idle_miss) begin
            miss_line <= {addr.tag, addr.set};
            wb_addr   <= {victim_tag, addr.set};
            wb_line   <= victim_line;
            fill_way  <= victim_way;
        end
        if ((state == st_fetch) && mem_rsp.gnt) begin
            fetched <= mem_rsp.rd_line;
        end
    end

endmodule

//--- logic/cache_top.sv
`include "cache_settings.svh"

module cache_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] addr,
    input  logic        rd_req,
    input  logic        wr_req,
    input  logic [31:0] wr_data,
    output logic        miss,
    output logic [31:0] rd_data
);

    cache_pkg::addr_fields_t addr_f;
    logic                    hit;
    cache_pkg::way_t         hit_way;
    logic [31:0]             hit_word;
    cache_pkg::tag_t         victim_tag;
    cache_pkg::line_t        victim_line;
    logic                    victim_dirty;
    cache_pkg::way_t         victim_way;
    cache_pkg::word_wr_t     word_wr;
    cache_pkg::fill_t        fill;
    cache_pkg::mem_req_t     mem_req;
    cache_pkg::mem_rsp_t     mem_rsp;

    assign addr_f = addr; // split into tag, set and word

    cache_ctrl ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr_f),
        .rd_req       (rd_req),
        .wr_req       (wr_req),
        .wr_data      (wr_data),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .victim_dirty (victim_dirty),
        .victim_way   (victim_way),
        .word_wr      (word_wr),
        .fill         (fill),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .miss         (miss),
        .rd_data      (rd_data)
    );

    cache_store store_i (
        .clk          (clk),
        .rst          (rst),
        .set          (addr_f.set),
        .tag          (addr_f.tag),
        .word_idx     (addr_f.word),
        .victim_way   (victim_way),
        .word_wr      (word_wr),
        .fill         (fill),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .victim_dirty (victim_dirty)
    );

    line_mem mem_i (
        .clk (clk),
        .rst (rst),
        .req (mem_req),
        .rsp (mem_rsp)
    );

endmodule

//--- test/cache_sva.sv
module cache_sva (
    input logic                 clk,
    input logic                 rst,
    input logic                 rd_req,
    input logic                 wr_req,
    input logic                 miss,
    input cache_pkg::mem_req_t  mem_req,
    input cache_pkg::mem_rsp_t  mem_rsp,
    input cache_pkg::fill_t     fill
);

    // one memory transfer at a time
    assert property (@(posedge clk) disable iff (rst)
        !(mem_req.rd && mem_req.wr))
        else $error("read and write strobes high together");

    // strobes are levels, dropped only after gnt
    assert property (@(posedge clk) disable iff (rst)
        (mem_req.rd && !mem_rsp.gnt) |=> mem_req.rd)
        else $error("read strobe dropped before gnt");

    assert property (@(posedge clk) disable iff (rst)
        (mem_req.wr && !mem_rsp.gnt) |=> mem_req.wr)
        else $error("write strobe dropped before gnt");

    // no request, no stall
    assert property (@(posedge clk) disable iff (rst)
        !(rd_req || wr_req) |-> !miss)
        else $error("miss high without a request");

    // install follows the fetch gnt directly
    assert property (@(posedge clk) disable iff (rst)
        fill.en |-> $past(mem_req.rd && mem_rsp.gnt))
        else $error("fill without a preceding read gnt");

endmodule

bind cache_ctrl cache_sva sva_i (
    .clk     (clk),
    .rst     (rst),
    .rd_req  (rd_req),
    .wr_req  (wr_req),
    .miss    (miss),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .fill    (fill)
);

//--- test/tb_cache.sv
`include "cache_settings.svh"

module tb_cache;

    localparam int IDX_W       = `CACHE_MEM_ADDR_LEN + `CACHE_LINE_ADDR_LEN; // word index
    localparam int EXP_HIT     = 0;
    localparam int EXP_MISS    = 1;
    localparam int EXP_ANY     = 2;
    localparam int RESET_CYC   = 10;
    localparam int ACCESS_CNT  = 225;                           // 9 + 2 + 8 + 6 + 200
    localparam int ACCESS_COST = 2 * `CACHE_MEM_LATENCY + 12;   // dirty miss plus slack
    localparam int LIMIT       = RESET_CYC + ACCESS_CNT * ACCESS_COST;

    logic        clk;
    logic        rst;
    logic [31:0] addr;
    logic        rd_req;
    logic        wr_req;
    logic [31:0] wr_data;
    logic        miss;
    logic [31:0] rd_data;

    logic [31:0] shadow [1 << IDX_W]; // expected memory image, per word
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          cycles;

    cache_top dut_i (
        .clk     (clk),
        .rst     (rst),
        .addr    (addr),
        .rd_req  (rd_req),
        .wr_req  (wr_req),
        .wr_data (wr_data),
        .miss    (miss),
        .rd_data (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]}; // one step per bit
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] make_addr(input cache_pkg::tag_t t, input cache_pkg::set_t s,
                                              input cache_pkg::word_idx_t w);
        cache_pkg::addr_fields_t f;
        f      = '0; // upper bits and byte offset stay zero
        f.tag  = t;
        f.set  = s;
        f.word = w;
        return f;
    endfunction

    // hold the request until served, then pick up rd_data
    task automatic do_access(input logic wr, input logic [31:0] a, input logic [31:0] d,
                             input int exp);
        logic             missed;
        logic [31:0]      q;
        logic [IDX_W-1:0] idx;
        idx = a[IDX_W+1:2];
        @(posedge clk);
        addr    <= a;
        rd_req  <= !wr;
        wr_req  <= wr;
        wr_data <= d;
        @(negedge clk);
        missed = miss; // first cycle tells hit or miss
        while (miss) begin
            @(negedge clk);
        end
        @(posedge clk);
        rd_req <= 1'b0;
        wr_req <= 1'b0;
        @(negedge clk);
        q = rd_data;
        if ((exp != EXP_ANY) && (missed != (exp == EXP_MISS))) begin
            $display("[ERROR] %0t miss = %b, expected %b (addr %h)",
                     $time, missed, (exp == EXP_MISS), a);
            errors++;
        end
        if (wr) begin
            shadow[idx] = d;
        end else begin
            checks++;
            if (q !== shadow[idx]) begin
                $display("[ERROR] %0t rd_data = %h, expected %h (addr %h)",
                         $time, q, shadow[idx], a);
                errors++;
            end
        end
    endtask

    task automatic read_line_test();
        do_access(1'b0, make_addr(6'd5, 3'd1, 3'd0), '0, EXP_MISS); // cold line
        for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
            do_access(1'b0, make_addr(6'd5, 3'd1, w[2:0]), '0, EXP_HIT);
        end
    endtask

    task automatic write_hit_test();
        do_access(1'b1, make_addr(6'd5, 3'd1, 3'd3), 32'hcafe_0001, EXP_HIT);
        do_access(1'b0, make_addr(6'd5, 3'd1, 3'd3), '0, EXP_HIT);
    endtask

    task automatic lru_test();
        for (int t = 10; t < 10 + `CACHE_WAY_CNT; t++) begin
            do_access(1'b0, make_addr(t[5:0], 3'd2, 3'd1), '0, EXP_MISS); // fill set 2
        end
        do_access(1'b0, make_addr(6'd10, 3'd2, 3'd2), '0, EXP_HIT);  // tag 11 now oldest
        do_access(1'b0, make_addr(6'd14, 3'd2, 3'd0), '0, EXP_MISS);
        do_access(1'b0, make_addr(6'd11, 3'd2, 3'd1), '0, EXP_MISS); // was evicted
        do_access(1'b0, make_addr(6'd10, 3'd2, 3'd7), '0, EXP_HIT);
    endtask

    task automatic writeback_test();
        do_access(1'b1, make_addr(6'd20, 3'd3, 3'd5), 32'hdead_beef, EXP_MISS); // allocate
        for (int t = 21; t < 25; t++) begin
            do_access(1'b0, make_addr(t[5:0], 3'd3, 3'd0), '0, EXP_MISS); // last one evicts
        end
        do_access(1'b0, make_addr(6'd20, 3'd3, 3'd5), '0, EXP_MISS); // back from memory
    endtask

    task automatic random_test();
        logic                 wr;
        cache_pkg::tag_t      t;
        cache_pkg::set_t      s;
        cache_pkg::word_idx_t w;
        logic [31:0]          d;
        for (int n = 0; n < 200; n++) begin
            wr = take_bits(1) != 0;
            t  = cache_pkg::tag_t'(take_bits(`CACHE_TAG_ADDR_LEN));
            s  = cache_pkg::set_t'(3'd4 + take_bits(1)); // sets 4 and 5
            w  = cache_pkg::word_idx_t'(take_bits(`CACHE_LINE_ADDR_LEN));
            d  = take_bits(32);
            do_access(wr, make_addr(t, s, w), d, EXP_ANY);
        end
    endtask

    initial begin
        rst     = 1'b1;
        addr    = '0;
        rd_req  = 1'b0;
        wr_req  = 1'b0;
        wr_data = '0;
        lfsr    = 32'h118b_4ab0;
        errors  = 0;
        checks  = 0;
        for (int i = 0; i < (1 << IDX_W); i++) begin
            shadow[i] = 32'h1000_0000 + i; // memory reset image
        end
        repeat (RESET_CYC) @(posedge clk);
        rst <= 1'b0;
        read_line_test();
        write_hit_test();
        lru_test();
        writeback_test();
        random_test();
        $display("summary: %0d reads checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d cycles", LIMIT);
        $display("summary: %0d reads checked, %0d errors", checks, errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
logic/cache_pkg.sv
logic/lru_tracker.sv
logic/cache_store.sv
logic/line_mem.sv
logic/cache_ctrl.sv
logic/cache_top.sv
test/cache_sva.sv
test/tb_cache.sv

//--- Bender.yml
package:
  name: cache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/cache_pkg.sv
      - logic/lru_tracker.sv
      - logic/cache_store.sv
      - logic/line_mem.sv
      - logic/cache_ctrl.sv
      - logic/cache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/cache_sva.sv
      - test/tb_cache.sv
